// File: logic/cpu_isa_pkg.sv
`default_nettype none

package cpu_isa_pkg;

typedef logic [4:0]  reg_addr_t;
typedef logic [31:0] uint32_t;

typedef struct packed {
	logic [5:0] opcode;
	reg_addr_t  rs;
	reg_addr_t  rt;
	reg_addr_t  rd;
	logic [4:0] shamt;
	logic [5:0] funct;
} instr_r_t;

typedef struct packed {
	logic [5:0]  opcode;
	reg_addr_t   rs;
	reg_addr_t   rt;
	logic [15:0] imm16;
} instr_i_t;

// same word, field layout chosen by opcode
typedef union packed {
	instr_r_t r;
	instr_i_t i;
} instr_t;

localparam logic [5:0] OP_SPECIAL  = 6'h00;
localparam logic [5:0] OP_BEQ      = 6'h04;
localparam logic [5:0] OP_BNE      = 6'h05;
localparam logic [5:0] OP_ADDIU    = 6'h09;
localparam logic [5:0] OP_ORI      = 6'h0d;
localparam logic [5:0] OP_LUI      = 6'h0f;
localparam logic [5:0] OP_SPECIAL2 = 6'h1c;

localparam logic [5:0] FN_MUL  = 6'h02;
localparam logic [5:0] FN_ADDU = 6'h21;
localparam logic [5:0] FN_SUBU = 6'h23;
localparam logic [5:0] FN_AND  = 6'h24;
localparam logic [5:0] FN_OR   = 6'h25;
localparam logic [5:0] FN_XOR  = 6'h26;
localparam logic [5:0] FN_SLT  = 6'h2a;

endpackage

`default_nettype wire

// File: logic/cpu_pipe_pkg.sv
`default_nettype none

package cpu_pipe_pkg;

import cpu_isa_pkg::*;

typedef enum logic [2:0] {
	ALU_ADD,
	ALU_SUB,
	ALU_AND,
	ALU_OR,
	ALU_XOR,
	ALU_SLT,
	ALU_LUI,
	ALU_MUL
} alu_op_t;

// IF/ID
typedef struct packed {
	logic    valid;
	uint32_t pc;
	instr_t  instr;
} fetch_entry_t;

// ID/EX
typedef struct packed {
	logic      valid;
	uint32_t   pc;
	alu_op_t   alu_op;
	uint32_t   operand_a;
	uint32_t   operand_b;
	logic      is_branch;
	logic      branch_ne;
	uint32_t   branch_target;
	reg_addr_t rd;
	logic      reg_write;
} decode_entry_t;

// EX/WB, also the forwarding record
typedef struct packed {
	logic      valid;
	reg_addr_t rd;
	uint32_t   wdata;
} wb_entry_t;

typedef struct packed {
	logic    taken;
	uint32_t target;
} branch_resolved_t;

endpackage

`default_nettype wire

// File: logic/cpu_ctrl_if.sv
`timescale 1ns/1ps
`default_nettype none

interface cpu_ctrl_if;

	// requests
	logic stall_from_if;
	logic stall_from_ex;
	logic branch_taken;

	// commands
	logic stall_if;
	logic stall_id;
	logic stall_ex;
	logic flush_if;
	logic flush_id;

	modport ctrl (
		input  stall_from_if, stall_from_ex, branch_taken,
		output stall_if, stall_id, stall_ex, flush_if, flush_id
	);

	modport fetch (
		output stall_from_if,
		input  stall_if, flush_if
	);

	modport exec (
		output stall_from_ex, branch_taken,
		input  stall_id, stall_ex, flush_id
	);

endinterface

`default_nettype wire

// File: logic/cpu_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_ctrl (
	input  logic     clk,
	input  logic     rst_n,
	cpu_ctrl_if.ctrl ctrl
);

logic flush_pending;
logic flush;
logic if_bubble;

// a redirect is applied only once EX no longer freezes the pipe
assign flush = (ctrl.branch_taken | flush_pending) & ~ctrl.stall_from_ex;

// fetch stall only matters when nothing downstream holds IF/ID
assign if_bubble = ctrl.stall_from_if & ~ctrl.stall_from_ex;

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		flush_pending <= 1'b0;
	end else begin
		flush_pending <= ctrl.branch_taken & ctrl.stall_from_ex;
	end
end

// EX stall freezes everything upstream
assign ctrl.stall_ex = ctrl.stall_from_ex;
assign ctrl.stall_id = ctrl.stall_from_ex;

// branch beats a pending fetch stall
assign ctrl.stall_if = ctrl.stall_from_ex | (ctrl.stall_from_if & ~flush);

// IF/ID gets an invalid entry on a redirect or a fetch bubble
assign ctrl.flush_if = flush | if_bubble;
assign ctrl.flush_id = flush;

endmodule

`default_nettype wire

// File: logic/regfile.sv
`timescale 1ns/1ps
`default_nettype none

module regfile import cpu_isa_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      we,
	input  reg_addr_t waddr,
	input  uint32_t   wdata,
	input  reg_addr_t raddr_a,
	input  reg_addr_t raddr_b,
	output uint32_t   rdata_a,
	output uint32_t   rdata_b
);

uint32_t regs [32];

function automatic uint32_t read_port(input reg_addr_t addr, input uint32_t stored,
		input logic wr_en, input reg_addr_t wr_addr, input uint32_t wr_data);
	uint32_t value;
	value = stored;
	// write in the same cycle passes straight through
	if (wr_en && wr_addr == addr) begin
		value = wr_data;
	end
	if (addr == '0) begin
		value = '0;
	end
	return value;
endfunction

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		for (int i = 0; i < 32; i++) begin
			regs[i] <= '0;
		end
	end else if (we && waddr != '0) begin
		regs[waddr] <= wdata;
	end
end

assign rdata_a = read_port(raddr_a, regs[raddr_a], we, waddr, wdata);
assign rdata_b = read_port(raddr_b, regs[raddr_b], we, waddr, wdata);

endmodule

`default_nettype wire

// File: logic/instr_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module instr_fetch import cpu_isa_pkg::*, cpu_pipe_pkg::*; #(
	parameter uint32_t RESET_PC = 32'h0000_0400
) (
	input  logic             clk,
	input  logic             rst_n,
	cpu_ctrl_if.fetch        ctrl,
	input  branch_resolved_t resolved,
	output logic             iread,
	output uint32_t          iaddr,
	input  instr_t           irdata,
	input  logic             istall,
	output fetch_entry_t     fetch_entry
);

uint32_t pc;

assign iaddr = pc;
assign ctrl.stall_from_if = iread & istall;

// bus idle for one cycle out of reset
always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		pc    <= RESET_PC;
		iread <= 1'b0;
	end else begin
		iread <= 1'b1;
		if (ctrl.flush_if && resolved.taken) begin
			pc <= resolved.target;
		end else if (iread && !ctrl.stall_if) begin
			pc <= pc + 32'd4;
		end
	end
end

// IF/ID register
always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		fetch_entry <= '0;
	end else if (ctrl.flush_if) begin
		fetch_entry <= '0;
	end else if (!ctrl.stall_if) begin
		fetch_entry.valid <= iread;
		fetch_entry.pc    <= pc;
		fetch_entry.instr <= irdata;
	end
end

endmodule

`default_nettype wire

// File: logic/decode_issue.sv
`timescale 1ns/1ps
`default_nettype none

module decode_issue import cpu_isa_pkg::*, cpu_pipe_pkg::*; (
	input  logic          clk,
	input  logic          rst_n,
	input  fetch_entry_t  fetch_entry,
	output reg_addr_t     raddr_a,
	output reg_addr_t     raddr_b,
	input  uint32_t       rdata_a,
	input  uint32_t       rdata_b,
	input  wb_entry_t     ex_fwd,
	input  wb_entry_t     wb_fwd,
	cpu_ctrl_if.exec      ctrl,
	output decode_entry_t decode_entry
);

instr_t        instr;
uint32_t       imm_sext;
uint32_t       imm_zext;
uint32_t       reg_a;
uint32_t       reg_b;
decode_entry_t decoded;

// EX result first, then WB, then register file
function automatic uint32_t forward(input reg_addr_t addr, input uint32_t rf_value,
		input wb_entry_t ex, input wb_entry_t wb);
	uint32_t value;
	value = rf_value;
	if (wb.valid && wb.rd == addr) begin
		value = wb.wdata;
	end
	if (ex.valid && ex.rd == addr) begin
		value = ex.wdata;
	end
	return value;
endfunction

assign instr    = fetch_entry.instr;
assign raddr_a  = instr.r.rs;
assign raddr_b  = instr.r.rt;
assign imm_sext = {{16{instr.i.imm16[15]}}, instr.i.imm16};
assign imm_zext = {16'h0000, instr.i.imm16};
assign reg_a    = forward(raddr_a, rdata_a, ex_fwd, wb_fwd);
assign reg_b    = forward(raddr_b, rdata_b, ex_fwd, wb_fwd);

always_comb begin
	decoded               = '0;
	decoded.valid         = fetch_entry.valid;
	decoded.pc            = fetch_entry.pc;
	decoded.alu_op        = ALU_ADD;
	decoded.operand_a     = reg_a;
	decoded.operand_b     = reg_b;
	decoded.branch_target = fetch_entry.pc + 32'd4 + {imm_sext[29:0], 2'b00};
	decoded.rd            = instr.r.rd;
	case (instr.r.opcode)
		OP_SPECIAL: begin
			decoded.reg_write = 1'b1;
			case (instr.r.funct)
				FN_ADDU: decoded.alu_op = ALU_ADD;
				FN_SUBU: decoded.alu_op = ALU_SUB;
				FN_AND:  decoded.alu_op = ALU_AND;
				FN_OR:   decoded.alu_op = ALU_OR;
				FN_XOR:  decoded.alu_op = ALU_XOR;
				FN_SLT:  decoded.alu_op = ALU_SLT;
				default: decoded.reg_write = 1'b0;
			endcase
		end
		OP_SPECIAL2: begin
			if (instr.r.funct == FN_MUL) begin
				decoded.alu_op    = ALU_MUL;
				decoded.reg_write = 1'b1;
			end
		end
		OP_ADDIU, OP_ORI, OP_LUI: begin
			// I-type destination is rt
			decoded.rd        = instr.i.rt;
			decoded.reg_write = 1'b1;
			decoded.operand_b = (instr.i.opcode == OP_ADDIU) ? imm_sext : imm_zext;
			if (instr.i.opcode == OP_ORI) begin
				decoded.alu_op = ALU_OR;
			end else if (instr.i.opcode == OP_LUI) begin
				decoded.alu_op = ALU_LUI;
			end
		end
		OP_BEQ, OP_BNE: begin
			decoded.is_branch = 1'b1;
			decoded.branch_ne = (instr.i.opcode == OP_BNE);
		end
		default: begin
			decoded.reg_write = 1'b0;
		end
	endcase
	// r0 is never written
	if (decoded.rd == '0 || !fetch_entry.valid) begin
		decoded.reg_write = 1'b0;
	end
end

// ID/EX register
always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		decode_entry <= '0;
	end else if (ctrl.flush_id) begin
		decode_entry <= '0;
	end else if (!ctrl.stall_id) begin
		decode_entry <= decoded;
	end
end

endmodule

`default_nettype wire

// File: logic/instr_exec.sv
`timescale 1ns/1ps
`default_nettype none

module instr_exec import cpu_isa_pkg::*, cpu_pipe_pkg::*; (
	input  logic             clk,
	input  logic             rst_n,
	input  decode_entry_t    decode_entry,
	cpu_ctrl_if.exec         ctrl,
	output wb_entry_t        ex_fwd,
	output branch_resolved_t resolved,
	output wb_entry_t        wb_entry
);

uint32_t op_a;
uint32_t op_b;
uint32_t alu_result;
logic    is_mul;
logic    mul_busy;
logic    mul_done;
logic    mul_stall;
uint32_t mul_acc;
uint32_t mul_mcand;
uint32_t mul_mplier;
uint32_t src_acc;
uint32_t src_mcand;
uint32_t src_mplier;
uint32_t step_acc;
uint32_t step_mcand;
uint32_t step_mplier;

assign op_a   = decode_entry.operand_a;
assign op_b   = decode_entry.operand_b;
assign is_mul = decode_entry.valid && decode_entry.alu_op == ALU_MUL;

// shift-add, first step straight from the operands
assign src_acc    = mul_busy ? mul_acc    : '0;
assign src_mcand  = mul_busy ? mul_mcand  : op_a;
assign src_mplier = mul_busy ? mul_mplier : op_b;

assign step_acc    = src_acc + (src_mplier[0] ? src_mcand : '0);
assign step_mcand  = src_mcand << 1;
assign step_mplier = src_mplier >> 1;

// done as soon as no multiplier bits remain
assign mul_done  = (step_mplier == '0);
assign mul_stall = is_mul && !mul_done;
assign ctrl.stall_from_ex = mul_stall;

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		mul_busy <= 1'b0;
	end else begin
		mul_busy <= mul_stall;
	end
end

always_ff @(posedge clk) begin
	if (is_mul) begin
		mul_acc    <= step_acc;
		mul_mcand  <= step_mcand;
		mul_mplier <= step_mplier;
	end
end

always_comb begin
	case (decode_entry.alu_op)
		ALU_ADD: alu_result = op_a + op_b;
		ALU_SUB: alu_result = op_a - op_b;
		ALU_AND: alu_result = op_a & op_b;
		ALU_OR:  alu_result = op_a | op_b;
		ALU_XOR: alu_result = op_a ^ op_b;
		ALU_SLT: alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
		ALU_LUI: alu_result = {op_b[15:0], 16'h0000};
		ALU_MUL: alu_result = step_acc;
		default: alu_result = '0;
	endcase
end

always_comb begin
	resolved.taken  = decode_entry.valid && decode_entry.is_branch &&
		((op_a == op_b) ^ decode_entry.branch_ne);
	resolved.target = decode_entry.branch_target;
	ex_fwd.valid    = decode_entry.valid && decode_entry.reg_write;
	ex_fwd.rd       = decode_entry.rd;
	ex_fwd.wdata    = alu_result;
end

assign ctrl.branch_taken = resolved.taken;

// EX/WB register, bubble while the multiplier iterates
always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		wb_entry <= '0;
	end else begin
		wb_entry       <= ex_fwd;
		wb_entry.valid <= ex_fwd.valid && !ctrl.stall_ex;
	end
end

endmodule

`default_nettype wire

// File: logic/cpu_core.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_core import cpu_isa_pkg::*, cpu_pipe_pkg::*; #(
	parameter uint32_t RESET_PC = 32'h0000_0400
) (
	input  logic      clk,
	input  logic      rst_n,
	output logic      iread,
	output uint32_t   iaddr,
	input  instr_t    irdata,
	input  logic      istall,
	output logic      wb_valid,
	output reg_addr_t wb_reg,
	output uint32_t   wb_data
);

fetch_entry_t     fetch_entry;
decode_entry_t    decode_entry;
wb_entry_t        ex_fwd;
wb_entry_t        wb_entry;
branch_resolved_t resolved;
reg_addr_t        raddr_a;
reg_addr_t        raddr_b;
uint32_t          rdata_a;
uint32_t          rdata_b;

cpu_ctrl_if ctrl_bus();

cpu_ctrl cpu_ctrl_i (
	.clk,
	.rst_n,
	.ctrl ( ctrl_bus.ctrl )
);

instr_fetch #(
	.RESET_PC ( RESET_PC )
) instr_fetch_i (
	.clk,
	.rst_n,
	.ctrl        ( ctrl_bus.fetch ),
	.resolved,
	.iread,
	.iaddr,
	.irdata,
	.istall,
	.fetch_entry
);

decode_issue decode_issue_i (
	.clk,
	.rst_n,
	.fetch_entry,
	.raddr_a,
	.raddr_b,
	.rdata_a,
	.rdata_b,
	.ex_fwd,
	.wb_fwd       ( wb_entry      ),
	.ctrl         ( ctrl_bus.exec ),
	.decode_entry
);

instr_exec instr_exec_i (
	.clk,
	.rst_n,
	.decode_entry,
	.ctrl     ( ctrl_bus.exec ),
	.ex_fwd,
	.resolved,
	.wb_entry
);

regfile regfile_i (
	.clk,
	.rst_n,
	.we      ( wb_entry.valid ),
	.waddr   ( wb_entry.rd    ),
	.wdata   ( wb_entry.wdata ),
	.raddr_a,
	.raddr_b,
	.rdata_a,
	.rdata_b
);

// writeback trace
assign wb_valid = wb_entry.valid;
assign wb_reg   = wb_entry.rd;
assign wb_data  = wb_entry.wdata;

endmodule

`default_nettype wire

// File: dv/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
	parameter int PERIOD_NS   = 40,
	parameter int RESET_CYCLES = 5
) (
	output logic clk,
	output logic rst_n
);

initial begin
	clk = 1'b0;
	forever #(PERIOD_NS / 2) clk = ~clk;
end

// release away from the rising edge
initial begin
	rst_n = 1'b0;
	repeat (RESET_CYCLES) @(posedge clk);
	@(negedge clk);
	rst_n = 1'b1;
end

endmodule

`default_nettype wire

// File: dv/cpu_core_checker.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_core_checker import cpu_isa_pkg::*; (
	input wire logic      clk,
	input wire logic      rst_n,
	input wire logic      iread,
	input wire uint32_t   iaddr,
	input wire logic      istall,
	input wire logic      wb_valid,
	input wire reg_addr_t wb_reg,
	input wire logic      redirect
);

// r0 writes never show on the trace
wb_reg_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
	wb_valid |-> wb_reg != '0)
	else $error("writeback reported for r0");

// a taken branch may move the PC during a bus stall
bus_hold: assert property (@(posedge clk) disable iff (!rst_n)
	(iread && istall && !redirect) |=> (iread && $stable(iaddr)))
	else $error("instruction bus request changed during istall");

iaddr_aligned: assert property (@(posedge clk) disable iff (!rst_n)
	iread |-> iaddr[1:0] == 2'b00)
	else $error("fetch address not word aligned");

endmodule

`default_nettype wire

// File: dv/cpu_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_core_tb import cpu_isa_pkg::*; ();

localparam uint32_t RESET_PC = 32'h0000_0400;

logic      clk;
logic      por_n;
logic      test_rst_n;
logic      rst_n;
logic      iread;
uint32_t   iaddr;
instr_t    irdata;
logic      istall;
logic      wb_valid;
reg_addr_t wb_reg;
uint32_t   wb_data;

uint32_t     prog [64];
int          prog_len;
reg_addr_t   exp_reg [$];
uint32_t     exp_data [$];
string       test_name;
int          stall_level;
logic [15:0] lfsr;

assign rst_n = por_n & test_rst_n;

tb_clock_gen clock_gen_i (
	.clk   ( clk   ),
	.rst_n ( por_n )
);

cpu_core #(
	.RESET_PC ( RESET_PC )
) cpu_core_i (
	.clk,
	.rst_n,
	.iread,
	.iaddr,
	.irdata,
	.istall,
	.wb_valid,
	.wb_reg,
	.wb_data
);

bind cpu_core cpu_core_checker cpu_core_checker_i (
	.clk,
	.rst_n,
	.iread,
	.iaddr,
	.istall,
	.wb_valid,
	.wb_reg,
	.redirect ( resolved.taken )
);

task automatic abort_run(input string why);
	$display("%s", why);
	$display("Testbench failed");
	$fatal(1, "simulation stopped");
endtask

task automatic check_reg(input string name, input reg_addr_t expected, input reg_addr_t actual);
	if (expected !== actual) begin
		$display("Fail %s register expected r%0d actual r%0d", name, expected, actual);
		abort_run("writeback went to the wrong register");
	end
endtask

task automatic check_word(input string name, input uint32_t expected, input uint32_t actual);
	if (expected !== actual) begin
		$display("Fail %s value expected 0x%08h actual 0x%08h", name, expected, actual);
		abort_run("value mismatch");
	end
endtask

function automatic logic [15:0] lfsr_next(input logic [15:0] state);
	logic [15:0] next;
	next = state >> 1;
	if (state[0]) begin
		next = next ^ 16'hb400;
	end
	return next;
endfunction

function automatic uint32_t r_word(input logic [5:0] op, input int rd, input int rs,
		input int rt, input logic [5:0] funct);
	instr_t w;
	w.r.opcode = op;
	w.r.rs     = reg_addr_t'(rs);
	w.r.rt     = reg_addr_t'(rt);
	w.r.rd     = reg_addr_t'(rd);
	w.r.shamt  = '0;
	w.r.funct  = funct;
	return w;
endfunction

function automatic uint32_t i_word(input logic [5:0] op, input int rt, input int rs,
		input logic [15:0] imm);
	instr_t w;
	w.i.opcode = op;
	w.i.rs     = reg_addr_t'(rs);
	w.i.rt     = reg_addr_t'(rt);
	w.i.imm16  = imm;
	return w;
endfunction

task automatic emit(input uint32_t w);
	prog[prog_len] = w;
	prog_len++;
endtask

task automatic load_program(input int sel);
	prog_len = 0;
	case (sel)
		0: begin
			emit(i_word(OP_ADDIU, 1, 0, 16'h1234));
			emit(i_word(OP_ADDIU, 2, 0, 16'hfffb));
			emit(i_word(OP_LUI, 3, 0, 16'habcd));
			emit(i_word(OP_ORI, 3, 3, 16'h5678));
			emit(r_word(OP_SPECIAL, 4, 1, 2, FN_ADDU));
			emit(r_word(OP_SPECIAL, 5, 2, 1, FN_SUBU));
			emit(r_word(OP_SPECIAL, 6, 3, 1, FN_AND));
			emit(r_word(OP_SPECIAL, 7, 3, 2, FN_OR));
			emit(r_word(OP_SPECIAL, 8, 3, 1, FN_XOR));
			emit(r_word(OP_SPECIAL, 9, 2, 1, FN_SLT));
			emit(r_word(OP_SPECIAL, 10, 1, 2, FN_SLT));
			emit(i_word(OP_ADDIU, 0, 1, 16'h0007));
			emit(r_word(OP_SPECIAL, 0, 1, 1, FN_ADDU));
		end
		1: begin
			emit(i_word(OP_ADDIU, 1, 0, 16'h0001));
			emit(r_word(OP_SPECIAL, 2, 1, 1, FN_ADDU));
			emit(r_word(OP_SPECIAL, 3, 2, 1, FN_ADDU));
			emit(r_word(OP_SPECIAL, 4, 3, 2, FN_ADDU));
			emit(r_word(OP_SPECIAL, 5, 4, 3, FN_SUBU));
			emit(r_word(OP_SPECIAL, 6, 5, 4, FN_XOR));
			emit(i_word(OP_ADDIU, 1, 1, 16'h0064));
			emit(r_word(OP_SPECIAL, 7, 1, 6, FN_ADDU));
		end
		2: begin
			emit(i_word(OP_ADDIU, 1, 0, 16'h0007));
			emit(i_word(OP_ADDIU, 2, 0, 16'h0009));
			emit(r_word(OP_SPECIAL2, 3, 1, 2, FN_MUL));
			emit(r_word(OP_SPECIAL, 4, 3, 1, FN_ADDU));
			emit(i_word(OP_LUI, 5, 0, 16'h1234));
			emit(i_word(OP_ORI, 5, 5, 16'h5678));
			emit(i_word(OP_ADDIU, 6, 0, 16'hffff));
			emit(r_word(OP_SPECIAL2, 7, 5, 6, FN_MUL));
			emit(r_word(OP_SPECIAL2, 8, 6, 6, FN_MUL));
			emit(r_word(OP_SPECIAL2, 10, 5, 0, FN_MUL));
			emit(r_word(OP_SPECIAL, 11, 7, 8, FN_ADDU));
		end
		default: begin
			emit(i_word(OP_ADDIU, 1, 0, 16'h0005));
			emit(i_word(OP_ADDIU, 2, 0, 16'h0005));
			emit(i_word(OP_BEQ, 2, 1, 16'h0002));
			emit(i_word(OP_ADDIU, 3, 0, 16'h0001));
			emit(i_word(OP_ADDIU, 4, 0, 16'h0002));
			emit(i_word(OP_ADDIU, 5, 0, 16'h0003));
			emit(i_word(OP_BNE, 2, 1, 16'h0001));
			emit(i_word(OP_ADDIU, 6, 0, 16'h0004));
			emit(i_word(OP_BNE, 5, 1, 16'h0001));
			emit(i_word(OP_ADDIU, 7, 0, 16'h0009));
			emit(i_word(OP_BEQ, 5, 1, 16'h0001));
			emit(i_word(OP_ADDIU, 8, 0, 16'h0006));
			emit(i_word(OP_ADDIU, 10, 0, 16'h0003));
			emit(i_word(OP_ADDIU, 9, 9, 16'h0001));
			emit(i_word(OP_BNE, 10, 9, 16'hfffe));
			emit(i_word(OP_ADDIU, 11, 9, 16'h000a));
		end
	endcase
	// branch-to-self closes every program
	emit(i_word(OP_BEQ, 0, 0, 16'hffff));
endtask

// architectural model of the program, one instruction per step
function automatic void build_expected();
	uint32_t   r [32];
	instr_t    w;
	uint32_t   a;
	uint32_t   b;
	uint32_t   sext;
	uint32_t   res;
	logic      wr;
	reg_addr_t dst;
	int        pc;
	int        next;
	int        steps;
	for (int k = 0; k < 32; k++) begin
		r[k] = '0;
	end
	exp_reg.delete();
	exp_data.delete();
	pc = 0;
	steps = 0;
	while (steps < 2000 && pc < prog_len) begin
		w    = prog[pc];
		a    = r[w.r.rs];
		b    = r[w.r.rt];
		sext = {{16{w.i.imm16[15]}}, w.i.imm16};
		wr   = 1'b1;
		dst  = w.r.rd;
		res  = '0;
		next = pc + 1;
		case (w.r.opcode)
			OP_SPECIAL: begin
				case (w.r.funct)
					FN_ADDU: res = a + b;
					FN_SUBU: res = a - b;
					FN_AND:  res = a & b;
					FN_OR:   res = a | b;
					FN_XOR:  res = a ^ b;
					FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					default: wr = 1'b0;
				endcase
			end
			OP_SPECIAL2: begin
				if (w.r.funct == FN_MUL) begin
					res = a * b;
				end else begin
					wr = 1'b0;
				end
			end
			OP_ADDIU: begin
				dst = w.i.rt;
				res = a + sext;
			end
			OP_ORI: begin
				dst = w.i.rt;
				res = a | {16'h0000, w.i.imm16};
			end
			OP_LUI: begin
				dst = w.i.rt;
				res = {w.i.imm16, 16'h0000};
			end
			OP_BEQ, OP_BNE: begin
				wr = 1'b0;
				if ((a == b) != (w.r.opcode == OP_BNE)) begin
					next = pc + 1 + int'($signed(sext));
				end
			end
			default: wr = 1'b0;
		endcase
		if (wr && dst != '0) begin
			r[dst] = res;
			exp_reg.push_back(dst);
			exp_data.push_back(res);
		end
		if (next == pc) begin
			break;
		end
		pc = next;
		steps++;
	end
endfunction

// memory model and bus stalls, both on the falling edge
always @(negedge clk) begin
	uint32_t idx;
	int      draw;
	idx = (iaddr - RESET_PC) >> 2;
	if (iaddr >= RESET_PC && idx < uint32_t'(prog_len)) begin
		irdata = prog[idx];
	end else begin
		irdata = {6'h00, iaddr[21:2] ^ {10'h000, iaddr[31:22]}, 6'h00};
	end
	draw = 0;
	if (stall_level != 0) begin
		for (int k = 0; k < 2; k++) begin
			draw = (draw << 1) | int'(lfsr[0]);
			lfsr = lfsr_next(lfsr);
		end
	end
	istall = (draw < stall_level);
end

// compare process
always @(negedge clk) begin
	if (rst_n && wb_valid) begin
		if (exp_reg.size() == 0) begin
			$display("unexpected writeback to r%0d in %s", wb_reg, test_name);
			abort_run("more writebacks than the program produces");
		end else begin
			check_reg(test_name, exp_reg.pop_front(), wb_reg);
			check_word(test_name, exp_data.pop_front(), wb_data);
		end
	end
end

task automatic run_test(input string name, input int sel, input int level);
	int      count;
	uint32_t end_pc;
	@(negedge clk);
	test_rst_n  = 1'b0;
	test_name   = name;
	stall_level = level;
	load_program(sel);
	build_expected();
	end_pc = RESET_PC + 32'(4 * (prog_len - 1));
	repeat (5) begin
		@(negedge clk);
		if (wb_valid !== 1'b0) begin
			abort_run("wb_valid high during reset");
		end
	end
	test_rst_n = 1'b1;
	count = 0;
	while (iread !== 1'b1) begin
		@(negedge clk);
		count++;
		if (count > 20) begin
			abort_run("no fetch after reset");
		end
	end
	check_word({name, " first fetch"}, RESET_PC, iaddr);
	count = 0;
	while (exp_reg.size() != 0) begin
		@(negedge clk);
		count++;
		if (count > 5000) begin
			abort_run("expected writebacks never arrived");
		end
	end
	count = 0;
	while (!(iread === 1'b1 && iaddr == end_pc)) begin
		@(negedge clk);
		count++;
		if (count > 200) begin
			abort_run("core never reached the final loop");
		end
	end
	// any stray pulse shows up here
	repeat (8) @(negedge clk);
endtask

initial begin
	int count;
	test_rst_n  = 1'b0;
	istall      = 1'b0;
	irdata      = '0;
	stall_level = 0;
	prog_len    = 0;
	lfsr        = 16'd64569;
	test_name   = "reset";
	count = 0;
	while (por_n !== 1'b1) begin
		@(negedge clk);
		count++;
		if (count > 20) begin
			abort_run("power-on reset never released");
		end
	end
	run_test("alu_ops", 0, 0);
	run_test("forwarding", 1, 0);
	run_test("mul", 2, 0);
	run_test("branches", 3, 0);
	run_test("alu_ops_stall", 0, 2);
	run_test("forwarding_stall", 1, 3);
	run_test("mul_stall", 2, 2);
	run_test("branches_stall", 3, 3);
	$display("Testbench passed");
	$finish;
end

endmodule

`default_nettype wire

// File: filelist.f
logic/cpu_isa_pkg.sv
logic/cpu_pipe_pkg.sv
logic/cpu_ctrl_if.sv
logic/cpu_ctrl.sv
logic/regfile.sv
logic/instr_fetch.sv
logic/decode_issue.sv
logic/instr_exec.sv
logic/cpu_core.sv
dv/tb_clock_gen.sv
dv/cpu_core_checker.sv
dv/cpu_core_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module cpu_core_tb -f filelist.f -o cpu_core_sim

sim_out=$(./obj_dir/cpu_core_sim)
echo "$sim_out"
echo "$sim_out" | grep -q "^Testbench passed$"
